//--- filelist.f
+incdir+bench
verilog/oks8_pkg.sv
verilog/oks8_alu.sv
verilog/oks8_decode.sv
verilog/oks8_uop_fifo.sv
verilog/oks8_execute.sv
verilog/oks8_core.sv
bench/oks8_tb.sv

//--- Makefile
# Verilator build and run for the OKS8 execute subsystem testbench

VERILATOR ?= verilator
TOP       ?= oks8_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/oks8_model.svh
// OKS8 reference model
// Register file, flags and skip bit stepped once per accepted instruction

`ifndef OKS8_MODEL_SVH
`define OKS8_MODEL_SVH

logic [7:0] ref_regs [8];
flags_t     ref_flags;
logic       ref_skip;

function automatic void clear_model();
	for (int i = 0; i < 8; i++)
		ref_regs[i] = 8'h00;
	ref_flags = '0;
	ref_skip  = 1'b0;
endfunction

// Value and next flags for one operation
function automatic void alu_ref(input op_e op, input logic [7:0] a, input logic [7:0] b,
		input flags_t fi, output logic [7:0] y, output flags_t fo);
	int sum;
	fo = fi;
	y  = a;
	case (op)
		AND: y = a & b;
		IOR: y = a | b;
		XOR: y = a ^ b;
		TCM: y = ~a & b;
		ADD, ADC:
		begin
			sum  = int'(a) + int'(b) + ((op == ADC) ? int'(fi.c) : 0);
			y    = sum[7:0];
			fo.c = (sum > 255);
			fo.v = (a[7] == b[7]) && (y[7] != a[7]);
		end
		SUB, SBC:
		begin
			// Negative difference means borrow
			sum  = int'(a) - int'(b) - ((op == SBC) ? int'(fi.c) : 0);
			y    = sum[7:0];
			fo.c = (sum < 0);
			fo.v = (a[7] != b[7]) && (y[7] != a[7]);
		end
		RR, RRC, SRA:
		begin
			// Incoming top bit depends on the flavour
			y    = {(op == RR) ? a[0] : ((op == RRC) ? fi.c : a[7]), a[7:1]};
			fo.c = a[0];
		end
		RL, RLC:
		begin
			y    = {a[6:0], (op == RL) ? a[7] : fi.c};
			fo.c = a[7];
		end
		LD: y = b;
		default: y = a;
	endcase
	// Everything up to SRA touches Z and S
	if (op <= SRA)
	begin
		fo.z = (y == 8'h00);
		fo.s = y[7];
	end
	if (op <= TCM || (op >= RR && op <= SRA))
		fo.v = 1'b0;
endfunction

// Condition table with invert in bit 3
function automatic bit skip_cond(input flags_t f, input logic [3:0] cc);
	bit c;
	case (cc[2:0])
		3'd0: c = 1'b0;
		3'd1: c = f.s ^ f.v;
		3'd2: c = f.z | (f.s ^ f.v);
		3'd3: c = f.c | f.z;
		3'd4: c = f.v;
		3'd5: c = f.s;
		3'd6: c = f.z;
		default: c = f.c;
	endcase
	return c ^ cc[3];
endfunction

// One accepted instruction, returns 1 when a result record is due
function automatic bit step_model(input instr_t ins, output result_t r);
	logic [7:0] b;
	logic [7:0] y;
	flags_t     fo;
	r = '0;
	if (ref_skip)
	begin
		ref_skip = 1'b0;
		return 1'b0;
	end
	if (ins.op == SKP)
	begin
		ref_skip = skip_cond(ref_flags, ins.src[3:0]);
		return 1'b0;
	end
	if (ins.op == NOP)
		return 1'b0;
	b = ins.imm ? ins.src : ref_regs[ins.src[2:0]];
	alu_ref(ins.op, ref_regs[ins.dst], b, ref_flags, y, fo);
	ref_regs[ins.dst] = y;
	ref_flags         = fo;
	r.dst   = ins.dst;
	r.value = y;
	r.flags = fo;
	return 1'b1;
endfunction

`endif

//--- bench/oks8_tb.sv
// OKS8 execute subsystem testbench
// Random instruction streams checked against a reference model
// Covers logic, arithmetic, shifts, skips, back-pressure and mid-stream reset

`timescale 1ns/1ns

module oks8_tb;

	import oks8_pkg::*;

	`include "oks8_model.svh"

	localparam int SEED      = 61847;
	localparam int N_SEED    = 8;
	localparam int N_LOGIC   = 40;
	localparam int N_ARITH   = 40;
	localparam int N_SHIFT   = 40;
	localparam int N_SKIP    = 16 * 4;
	localparam int N_BP      = 60;
	localparam int N_RST_PRE = 12;
	localparam int N_RST_CHK = 9;
	localparam int N_TOTAL   = N_SEED + N_LOGIC + N_ARITH + N_SHIFT + N_SKIP + N_BP
		+ N_RST_PRE + N_RST_CHK;
	localparam int TIMEOUT_CYCLES = 8 * N_TOTAL + 200;

	logic    clk_i;
	logic    rst_i;
	logic    in_valid_i;
	logic    in_ready_o;
	instr_t  in_instr_i;
	logic    res_valid_o;
	logic    res_ready_i = 1'b0;
	result_t res_o;

	result_t exp_q [$];
	result_t exp_rec;
	result_t new_rec;
	string   test_name = "init";
	bit      bp_mode = 1'b0;
	bit      ready_level = 1'b0;
	int      ready_run = 0;
	int      cycle_cnt = 0;

	oks8_core #(
		.UOP_DEPTH (4)
	) UUT (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_instr_i  (in_instr_i),
		.res_valid_o (res_valid_o),
		.res_ready_i (res_ready_i),
		.res_o       (res_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// ====================
	// Failure and checks
	// ====================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_result(input string name, input result_t exp, input result_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flags(input string name, input flags_t exp, input flags_t act);
		if (act !== exp)
			fail_run($sformatf("mismatch %s flags czsv: expected %b, actual %b",
				name, exp, act));
	endtask

	always @(posedge clk_i)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	// Handshakes sampled at the falling edge before they complete
	always @(negedge clk_i)
	begin
		if (!rst_i)
		begin
			if (res_valid_o && res_ready_i)
			begin
				if (exp_q.size() == 0)
					fail_run("DUT issued a result that the model did not expect");
				exp_rec = exp_q.pop_front();
				check_flags(test_name, exp_rec.flags, res_o.flags);
				check_result(test_name, exp_rec, res_o);
			end
			if (in_valid_i && in_ready_o)
			begin
				if (step_model(in_instr_i, new_rec))
					exp_q.push_back(new_rec);
			end
		end
	end

	// Random result ready with long low runs under back-pressure
	always @(posedge clk_i)
	begin
		#1;
		if (ready_run == 0)
		begin
			ready_level = !ready_level;
			if (ready_level)
				ready_run = bp_mode ? $urandom_range(16, 4) : $urandom_range(6, 1);
			else
				ready_run = bp_mode ? $urandom_range(40, 10) : $urandom_range(2, 0);
		end
		else
			ready_run = ready_run - 1;
		res_ready_i = ready_level;
	end

	// ====================
	// Stimulus helpers
	// ====================
	function automatic instr_t make_instr(input op_e op, input logic [2:0] dst,
			input logic [7:0] src);
		instr_t ins;
		ins.op  = op;
		ins.imm = 1'b1;
		ins.dst = dst;
		ins.src = src;
		return ins;
	endfunction

	function automatic instr_t rand_instr(input int lo, input int hi);
		instr_t ins;
		ins.op  = op_e'(4'($urandom_range(hi, lo)));
		ins.imm = 1'($urandom_range(1, 0));
		ins.dst = 3'($urandom_range(7, 0));
		ins.src = 8'($urandom);
		return ins;
	endfunction

	// Entered and left 1 ns after a rising edge
	task automatic send_instr(input instr_t ins);
		in_valid_i = 1'b1;
		in_instr_i = ins;
		@(negedge clk_i);
		while (!in_ready_o)
			@(negedge clk_i);
		@(posedge clk_i);
		#1;
		in_valid_i = 1'b0;
		repeat ($urandom_range(2, 0))
		begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
		begin
			@(posedge clk_i);
			#1;
		end
	endtask

	// Nothing left once decoder stage, FIFO and result register are empty
	task automatic wait_idle();
		@(negedge clk_i);
		while (UUT.dec_valid || UUT.fifo_valid || res_valid_o)
			@(negedge clk_i);
		@(posedge clk_i);
		#1;
	endtask

	task automatic apply_reset(input int cycles);
		rst_i = 1'b1;
		clear_model();
		exp_q.delete();
		repeat (cycles)
		begin
			@(posedge clk_i);
			#1;
		end
		rst_i = 1'b0;
	endtask

	task automatic run_random(input string name, input int lo, input int hi, input int n);
		test_name = name;
		for (int i = 0; i < n; i++)
			send_instr(rand_instr(lo, hi));
		wait_drain();
	endtask

	// All 16 codes, each SKP guarding an LD
	task automatic skip_sweep();
		test_name = "skip";
		for (int cc = 0; cc < 16; cc++)
		begin
			send_instr(rand_instr(4, 7));
			send_instr(make_instr(SKP, 3'd0, 8'(cc)));
			send_instr(make_instr(LD, 3'(cc), 8'($urandom)));
			send_instr(make_instr(NOP, 3'd0, 8'(cc)));
		end
		wait_drain();
	endtask

	task automatic reset_midstream();
		test_name = "reset";
		bp_mode   = 1'b1;
		for (int i = 0; i < N_RST_PRE; i++)
			send_instr(rand_instr(0, 15));
		// Pipeline is backed up here
		apply_reset(10);
		bp_mode = 1'b0;
		@(negedge clk_i);
		if (res_valid_o || !in_ready_o)
			fail_run("pipeline did not return to idle after reset");
		@(posedge clk_i);
		#1;
		// Zero only if C came out of reset cleared
		send_instr(make_instr(ADC, 3'd0, 8'h00));
		for (int r = 0; r < 8; r++)
			send_instr(make_instr(ADD, 3'(r), 8'h00));
		wait_idle();
	endtask

	// ====================
	// Test sequence
	// ====================
	initial
	begin
		void'($urandom(SEED));
		rst_i      = 1'b1;
		in_valid_i = 1'b0;
		in_instr_i = '0;
		apply_reset(10);
		test_name = "logic";
		// Fill the registers first
		for (int r = 0; r < N_SEED; r++)
			send_instr(make_instr(LD, 3'(r), 8'($urandom)));
		run_random("logic", 0, 3, N_LOGIC);
		run_random("arith", 4, 7, N_ARITH);
		run_random("shift", 8, 12, N_SHIFT);
		skip_sweep();
		bp_mode = 1'b1;
		run_random("backpressure", 0, 15, N_BP);
		bp_mode = 1'b0;
		reset_midstream();
		if (exp_q.size() != 0)
			fail_run("expected results were never issued");
		else
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- verilog/oks8_core.sv
// OKS8 execute subsystem top level
// Decoder feeds the micro-op FIFO, FIFO feeds the execute unit

`timescale 1ns/1ns

module oks8_core #(
	parameter int UOP_DEPTH = oks8_pkg::UOP_DEPTH_DEF
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              in_valid_i,
	output logic              in_ready_o,
	input  oks8_pkg::instr_t  in_instr_i,
	output logic              res_valid_o,
	input  logic              res_ready_i,
	output oks8_pkg::result_t res_o
);

	import oks8_pkg::*;

	// Decoder to FIFO
	logic dec_valid;
	logic dec_ready;
	uop_t dec_uop;

	// FIFO to execute
	logic fifo_valid;
	logic fifo_ready;
	uop_t fifo_uop;

	oks8_decode decode_u (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_instr_i  (in_instr_i),
		.dec_ready_i (dec_ready),
		.in_ready_o  (in_ready_o),
		.dec_valid_o (dec_valid),
		.dec_uop_o   (dec_uop)
	);

	oks8_uop_fifo #(
		.DEPTH (UOP_DEPTH)
	) fifo_u (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.push_valid_i (dec_valid),
		.push_uop_i   (dec_uop),
		.pop_ready_i  (fifo_ready),
		.push_ready_o (dec_ready),
		.pop_valid_o  (fifo_valid),
		.pop_uop_o    (fifo_uop)
	);

	oks8_execute execute_u (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.uop_valid_i (fifo_valid),
		.uop_i       (fifo_uop),
		.res_ready_i (res_ready_i),
		.uop_ready_o (fifo_ready),
		.res_valid_o (res_valid_o),
		.res_o       (res_o)
	);

endmodule

//--- verilog/oks8_execute.sv
// OKS8 execute unit
// Eight 8-bit registers, C/Z/S/V flags and a pending skip
// One micro-op per cycle, register writes issue a result record

`timescale 1ns/1ns

module oks8_execute (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              uop_valid_i,
	input  oks8_pkg::uop_t    uop_i,
	input  logic              res_ready_i,
	output logic              uop_ready_o,
	output logic              res_valid_o,
	output oks8_pkg::result_t res_o
);

	import oks8_pkg::*;

	logic [7:0] regs [8];
	flags_t     flags;
	logic       skip_pend;
	logic [7:0] src_val;
	logic [7:0] dst_val;
	logic [7:0] alu_value;
	flags_t     alu_flags;
	logic       cond_raw;
	logic       cond_true;
	logic       accept;
	logic       do_write;

	// Stall while a result sits unread
	assign uop_ready_o = !res_valid_o || res_ready_i;
	assign accept      = uop_valid_i && uop_ready_o;
	assign do_write    = accept && !skip_pend && uop_i.writes;

	// Operands
	assign src_val = uop_i.imm ? uop_i.src : regs[uop_i.src[2:0]];
	assign dst_val = regs[uop_i.dst];

	oks8_alu alu_u (
		.uop_i     (uop_i),
		.dst_val_i (dst_val),
		.src_val_i (src_val),
		.flags_i   (flags),
		.value_o   (alu_value),
		.flags_o   (alu_flags)
	);

	// ====================
	// Skip condition
	// ====================
	always_comb
	begin
		unique case (uop_i.src[2:0])
			3'b000: cond_raw = 1'b0;
			3'b001: cond_raw = flags.s ^ flags.v;
			3'b010: cond_raw = flags.z | (flags.s ^ flags.v);
			3'b011: cond_raw = flags.c | flags.z;
			3'b100: cond_raw = flags.v;
			3'b101: cond_raw = flags.s;
			3'b110: cond_raw = flags.z;
			default: cond_raw = flags.c;
		endcase
	end

	// Bit 3 inverts
	assign cond_true = cond_raw ^ uop_i.src[3];

	// ====================
	// Architectural state
	// ====================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= 8'h00;
			flags       <= '0;
			skip_pend   <= 1'b0;
			res_valid_o <= 1'b0;
		end
		else
		begin
			if (res_ready_i)
				res_valid_o <= 1'b0;
			if (accept)
			begin
				// Skipped micro-op is swallowed
				if (skip_pend)
					skip_pend <= 1'b0;
				else if (uop_i.op == SKP)
					skip_pend <= cond_true;
				else if (uop_i.writes)
				begin
					regs[uop_i.dst] <= alu_value;
					flags           <= alu_flags;
					res_valid_o     <= 1'b1;
				end
			end
		end
	end

	// Result record
	always_ff @(posedge clk_i)
	begin
		if (do_write)
		begin
			res_o.dst   <= uop_i.dst;
			res_o.value <= alu_value;
			res_o.flags <= alu_flags;
		end
	end

	// Held result keeps its payload and freezes the flags
	a_res_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o) && $stable(flags));

endmodule

//--- verilog/oks8_uop_fifo.sv
// OKS8 micro-op FIFO
// Circular buffer between decoder and execute unit
// Push and pop may happen in the same cycle

`timescale 1ns/1ns

module oks8_uop_fifo #(
	parameter int DEPTH = oks8_pkg::UOP_DEPTH_DEF
) (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           push_valid_i,
	input  oks8_pkg::uop_t push_uop_i,
	input  logic           pop_ready_i,
	output logic           push_ready_o,
	output logic           pop_valid_o,
	output oks8_pkg::uop_t pop_uop_o
);

	import oks8_pkg::*;

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	uop_t          mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// Pointer step with wrap at DEPTH
	function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
		if (p == PW'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign push_ready_o = (count != CW'(DEPTH));
	assign pop_valid_o  = (count != '0);
	assign pop_uop_o    = mem[rd_ptr];

	assign do_push = push_valid_i && push_ready_o;
	assign do_pop  = pop_valid_o && pop_ready_i;

	// ====================
	// Pointers and count
	// ====================
	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			// Net change only when one side moves
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk_i)
	begin
		if (do_push)
			mem[wr_ptr] <= push_uop_i;
	end

	a_fifo_count: assert property (@(posedge clk_i) disable iff (rst_i)
		count <= CW'(DEPTH));

	// Empty means the read pointer never ran past the write pointer
	a_fifo_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
		count == '0 |-> rd_ptr == wr_ptr);

endmodule

//--- verilog/oks8_decode.sv
// OKS8 instruction decoder
// Single register stage with valid/ready on both sides
// Turns an instruction word into a micro-op with flag class and write bit

`timescale 1ns/1ns

module oks8_decode (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             in_valid_i,
	input  oks8_pkg::instr_t in_instr_i,
	input  logic             dec_ready_i,
	output logic             in_ready_o,
	output logic             dec_valid_o,
	output oks8_pkg::uop_t   dec_uop_o
);

	import oks8_pkg::*;

	uop_t nxt_uop;

	// ====================
	// Classification
	// ====================
	always_comb
	begin
		nxt_uop.op  = in_instr_i.op;
		nxt_uop.dst = in_instr_i.dst;
		nxt_uop.imm = in_instr_i.imm;
		nxt_uop.src = in_instr_i.src;
		// Flag class per opcode group
		unique case (in_instr_i.op)
			AND, IOR, XOR, TCM:
				nxt_uop.fclass = FL_LOGIC;
			ADD, ADC, SUB, SBC:
				nxt_uop.fclass = FL_ARITH;
			RR, RL, RRC, RLC, SRA:
				nxt_uop.fclass = FL_SHIFT;
			default:
				nxt_uop.fclass = FL_NONE;
		endcase
		// Skip and no-op leave the register file alone
		nxt_uop.writes = !(in_instr_i.op inside {SKP, NOP});
	end

	// ====================
	// Stage register
	// ====================

	// Empty, or being drained this cycle
	assign in_ready_o = !dec_valid_o || dec_ready_i;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			dec_valid_o <= 1'b0;
		else if (in_ready_o)
			dec_valid_o <= in_valid_i;
	end

	// Payload only loads on an accepted word
	always_ff @(posedge clk_i)
	begin
		if (in_valid_i && in_ready_o)
			dec_uop_o <= nxt_uop;
	end

	// Stalled output holds valid and payload
	a_dec_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_uop_o));

endmodule

//--- verilog/oks8_alu.sv
// OKS8 ALU
// Combinational 9-bit datapath, bit 8 is the carry/borrow/shifted-out bit
// Flag class of the micro-op picks which flags follow the result

`timescale 1ns/1ns

module oks8_alu (
	input  oks8_pkg::uop_t   uop_i,
	input  logic [7:0]       dst_val_i,
	input  logic [7:0]       src_val_i,
	input  oks8_pkg::flags_t flags_i,
	output logic [7:0]       value_o,
	output oks8_pkg::flags_t flags_o
);

	import oks8_pkg::*;

	logic [8:0] res;
	logic       op2_sign;
	logic       ovf;

	// ====================
	// Result
	// ====================
	always_comb
	begin
		unique case (uop_i.op)
			AND: res = {flags_i.c, dst_val_i & src_val_i};
			IOR: res = {flags_i.c, dst_val_i | src_val_i};
			XOR: res = {flags_i.c, dst_val_i ^ src_val_i};
			TCM: res = {flags_i.c, ~dst_val_i & src_val_i};
			// Carry out lands in bit 8
			ADD: res = {1'b0, dst_val_i} + {1'b0, src_val_i};
			ADC: res = {1'b0, dst_val_i} + {1'b0, src_val_i} + 9'(flags_i.c);
			// Wrap into bit 8 gives the borrow
			SUB: res = {1'b0, dst_val_i} - {1'b0, src_val_i};
			SBC: res = {1'b0, dst_val_i} - {1'b0, src_val_i} - 9'(flags_i.c);
			RR:  res = {dst_val_i[0], dst_val_i[0], dst_val_i[7:1]};
			RL:  res = {dst_val_i[7], dst_val_i[6:0], dst_val_i[7]};
			// Through carry
			RRC: res = {dst_val_i[0], flags_i.c, dst_val_i[7:1]};
			RLC: res = {dst_val_i[7], dst_val_i[6:0], flags_i.c};
			SRA: res = {dst_val_i[0], dst_val_i[7], dst_val_i[7:1]};
			LD:  res = {flags_i.c, src_val_i};
			default:
				res = {flags_i.c, dst_val_i};
		endcase
	end

	assign value_o = res[7:0];

	// Subtract compares against the negated operand sign
	assign op2_sign = (uop_i.op inside {SUB, SBC}) ? ~src_val_i[7] : src_val_i[7];
	assign ovf      = (dst_val_i[7] == op2_sign) && (res[7] != dst_val_i[7]);

	// ====================
	// Next flags
	// ====================
	always_comb
	begin
		flags_o = flags_i;
		unique case (uop_i.fclass)
			FL_LOGIC:
			begin
				flags_o.z = (res[7:0] == 8'h00);
				flags_o.s = res[7];
				flags_o.v = 1'b0;
			end
			FL_ARITH:
			begin
				flags_o.c = res[8];
				flags_o.z = (res[7:0] == 8'h00);
				flags_o.s = res[7];
				flags_o.v = ovf;
			end
			FL_SHIFT:
			begin
				flags_o.c = res[8];
				flags_o.z = (res[7:0] == 8'h00);
				flags_o.s = res[7];
				flags_o.v = 1'b0;
			end
			default:
				flags_o = flags_i;
		endcase
	end

endmodule

//--- verilog/oks8_pkg.sv
// OKS8 execute subsystem shared definitions
// Opcodes, flag classes, instruction layout, micro-op and result records

package oks8_pkg;

	// ====================
	// Opcodes and flag classes
	// ====================

	// ALU set first, then load, skip and no-op
	typedef enum logic [3:0] {
		AND,
		IOR,
		XOR,
		TCM,
		ADD,
		ADC,
		SUB,
		SBC,
		RR,
		RL,
		RRC,
		RLC,
		SRA,
		LD,
		SKP,
		NOP
	} op_e;

	// How an operation touches C/Z/S/V
	typedef enum logic [1:0] {
		FL_NONE,
		FL_LOGIC,
		FL_ARITH,
		FL_SHIFT
	} flag_class_e;

	// ====================
	// Records
	// ====================

	typedef struct packed {
		logic c;
		logic z;
		logic s;
		logic v;
	} flags_t;

	// 16-bit instruction word
	typedef struct packed {
		op_e        op;
		logic       imm;
		logic [2:0] dst;
		// Immediate, register index in [2:0], or skip condition in [3:0]
		logic [7:0] src;
	} instr_t;

	typedef struct packed {
		op_e         op;
		flag_class_e fclass;
		logic [2:0]  dst;
		logic        imm;
		logic [7:0]  src;
		logic        writes;
	} uop_t;

	typedef struct packed {
		logic [2:0] dst;
		logic [7:0] value;
		flags_t     flags;
	} result_t;

	// Default micro-op FIFO depth
	localparam int UOP_DEPTH_DEF = 4;

endpackage
